/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_neural_network
LOG       ?= sim.log
FLIST     ?= flist.f
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim: build
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* common/nn_ctrl_pkg.sv */
package nn_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        L1_MM,
        L1_RELU,
        L2_MM,
        ARGMAX,
        DONE
    } nn_state_t;

    // Strobe pair between the sequencer and one layer unit
    typedef struct packed {
        logic start;
        logic done;
    } layer_run_t;

endpackage

/* common/nn_data_pkg.sv */
package nn_data_pkg;

    localparam int N_PIXELS  = 64;
    localparam int N_HIDDEN  = 16;
    localparam int N_CLASSES = 10;

    // Bit index into the latched image
    localparam int PIX_W = $clog2(N_PIXELS);

    // Sized for the largest weight table, N_HIDDEN rows of N_PIXELS
    localparam int ADDR_W = $clog2(N_PIXELS * N_HIDDEN);

    typedef logic signed [31:0] act_t;
    typedef logic signed [7:0]  wgt_t;
    typedef logic [ADDR_W-1:0]  addr_t;

    // One write into a scratch RAM
    typedef struct packed {
        addr_t addr;
        act_t  data;
        logic  we;
    } mem_wr_t;

endpackage

/* flist.f */
common/nn_data_pkg.sv
common/nn_ctrl_pkg.sv
src/scratch_ram.sv
src/weight_rom.sv
layer/matrix_multiply.sv
layer/relu.sv
src/argmax.sv
src/neural_network.sv
tb/nn_props.sv
tb/tb_neural_network.sv

/* layer/matrix_multiply.sv */
`timescale 1ns/1ps

module matrix_multiply #(
    parameter int IN_LEN  = 64,
    parameter int OUT_LEN = 16
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 start,
    output nn_data_pkg::addr_t   src_addr,
    input  nn_data_pkg::act_t    src_data,
    output nn_data_pkg::addr_t   wgt_addr,
    input  nn_data_pkg::wgt_t    wgt_data,
    output nn_data_pkg::mem_wr_t wr,
    output logic                 done
);
    import nn_data_pkg::*;

    localparam addr_t IN_A     = addr_t'(IN_LEN);
    localparam addr_t LAST_IN  = addr_t'(IN_LEN + 1);
    localparam addr_t LAST_OUT = addr_t'(OUT_LEN - 1);

    logic  busy;
    addr_t in_cnt;
    addr_t out_cnt;
    addr_t in_cnt_q;
    logic  acc_en;
    logic  row_end;
    act_t  acc;
    act_t  prod;

    // Row takes IN_LEN reads, one trailing accumulate, then the write
    assign row_end = busy && (in_cnt == LAST_IN);
    assign prod    = src_data * act_t'(wgt_data);

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            busy     <= 1'b0;
            in_cnt   <= '0;
            out_cnt  <= '0;
            in_cnt_q <= '0;
            acc_en   <= 1'b0;
            acc      <= '0;
        end else begin
            in_cnt_q <= in_cnt;
            acc_en   <= busy && (in_cnt < IN_A);

            if (start) begin
                busy    <= 1'b1;
                in_cnt  <= '0;
                out_cnt <= '0;
            end else if (busy) begin
                if (row_end) begin
                    in_cnt <= '0;
                    if (out_cnt == LAST_OUT) begin
                        busy <= 1'b0;
                    end else begin
                        out_cnt <= out_cnt + 1'b1;
                    end
                end else begin
                    in_cnt <= in_cnt + 1'b1;
                end
            end

            if (acc_en) begin
                acc <= acc + prod;
            end else if (row_end) begin
                acc <= '0;
            end
        end
    end

    assign src_addr = in_cnt;

    // Weight index trails the read address to match the RAM latency
    assign wgt_addr = out_cnt * IN_A + in_cnt_q;

    assign wr.addr = out_cnt;
    assign wr.data = acc;
    assign wr.we   = row_end;
    assign done    = row_end && (out_cnt == LAST_OUT);

endmodule

/* layer/relu.sv */
`timescale 1ns/1ps

module relu #(
    parameter int LEN = 16
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 start,
    output nn_data_pkg::addr_t   src_addr,
    input  nn_data_pkg::act_t    src_data,
    output nn_data_pkg::mem_wr_t wr,
    output logic                 done
);
    import nn_data_pkg::*;

    localparam addr_t LEN_A = addr_t'(LEN);
    localparam addr_t LAST  = addr_t'(LEN + 1);

    logic  busy;
    addr_t cnt;
    addr_t idx_q;
    logic  rd_vld;

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            busy   <= 1'b0;
            cnt    <= '0;
            idx_q  <= '0;
            rd_vld <= 1'b0;
            wr     <= '0;
        end else begin
            idx_q  <= cnt;
            rd_vld <= busy && (cnt < LEN_A);

            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                if (cnt == LAST) begin
                    busy <= 1'b0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end

            // Same index, negatives clamped
            wr.addr <= idx_q;
            wr.data <= (src_data < 0) ? '0 : src_data;
            wr.we   <= rd_vld;
        end
    end

    assign src_addr = cnt;
    assign done     = busy && (cnt == LAST);

endmodule

/* src/argmax.sv */
`timescale 1ns/1ps

module argmax #(
    parameter int LEN = 10
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               start,
    output nn_data_pkg::addr_t src_addr,
    input  nn_data_pkg::act_t  src_data,
    output logic [3:0]         max_index,
    output logic               done
);
    import nn_data_pkg::*;

    localparam addr_t LEN_A = addr_t'(LEN);
    localparam addr_t LAST  = addr_t'(LEN + 1);

    logic  busy;
    addr_t cnt;
    addr_t idx_q;
    logic  rd_vld;
    act_t  best;

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            busy      <= 1'b0;
            cnt       <= '0;
            idx_q     <= '0;
            rd_vld    <= 1'b0;
            best      <= '0;
            max_index <= '0;
        end else begin
            idx_q  <= cnt;
            rd_vld <= busy && (cnt < LEN_A);

            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                if (cnt == LAST) begin
                    busy <= 1'b0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end

            // First word always loads, later ones only if strictly greater
            if (rd_vld && ((idx_q == '0) || (src_data > best))) begin
                best      <= src_data;
                max_index <= idx_q[3:0];
            end
        end
    end

    assign src_addr = cnt;
    assign done     = busy && (cnt == LAST);

endmodule

/* src/neural_network.sv */
`timescale 1ns/1ps

module neural_network (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          start,
    input  logic [nn_data_pkg::N_PIXELS-1:0] pixel_data,
    output logic                          done,
    output logic [3:0]                    class_index
);
    import nn_data_pkg::*;
    import nn_ctrl_pkg::*;

    nn_state_t state;
    nn_state_t state_nx;
    nn_state_t state_q;

    logic [N_PIXELS-1:0] image_q;
    logic [PIX_W-1:0]    pix_idx;
    act_t                pix_data;

    layer_run_t run_mm1;
    layer_run_t run_relu1;
    layer_run_t run_mm2;
    layer_run_t run_am;

    logic mm1_done;
    logic relu1_done;
    logic mm2_done;
    logic am_done;

    addr_t      mm1_src_addr;
    addr_t      mm1_wgt_addr;
    addr_t      relu1_src_addr;
    addr_t      mm2_src_addr;
    addr_t      mm2_wgt_addr;
    addr_t      am_src_addr;
    wgt_t       w1_data;
    wgt_t       w2_data;
    act_t       h1_rd_data;
    act_t       a1_rd_data;
    act_t       s2_rd_data;
    mem_wr_t    h1_wr;
    mem_wr_t    a1_wr;
    mem_wr_t    s2_wr;
    logic [3:0] am_index;

    // Image capture and the layer-1 source, which mimics a RAM read
    assign pix_idx = mm1_src_addr[PIX_W-1:0];

    always_ff @(posedge clk) begin
        if ((state == IDLE) && start) begin
            image_q <= pixel_data;
        end
        pix_data <= act_t'(image_q[pix_idx]);
    end

    // A unit starts in the first cycle of its state
    always_comb begin
        run_mm1.start   = (state == L1_MM) && (state_q != L1_MM);
        run_mm1.done    = mm1_done;
        run_relu1.start = (state == L1_RELU) && (state_q != L1_RELU);
        run_relu1.done  = relu1_done;
        run_mm2.start   = (state == L2_MM) && (state_q != L2_MM);
        run_mm2.done    = mm2_done;
        run_am.start    = (state == ARGMAX) && (state_q != ARGMAX);
        run_am.done     = am_done;
    end

    always_comb begin
        state_nx = state;
        case (state)
            IDLE:    if (start) state_nx = L1_MM;
            L1_MM:   if (run_mm1.done) state_nx = L1_RELU;
            L1_RELU: if (run_relu1.done) state_nx = L2_MM;
            L2_MM:   if (run_mm2.done) state_nx = ARGMAX;
            ARGMAX:  if (run_am.done) state_nx = DONE;
            DONE:    state_nx = IDLE;
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            state       <= IDLE;
            state_q     <= IDLE;
            class_index <= '0;
        end else begin
            state   <= state_nx;
            state_q <= state;
            if (run_am.done) begin
                class_index <= am_index;
            end
        end
    end

    assign done = (state == DONE);

    weight_rom #(.LAYER(1)) w1 (.addr(mm1_wgt_addr), .weight(w1_data));
    weight_rom #(.LAYER(2)) w2 (.addr(mm2_wgt_addr), .weight(w2_data));

    scratch_ram #(.DEPTH(N_HIDDEN)) h1 (
        .clk(clk), .wr(h1_wr), .rd_addr(relu1_src_addr), .rd_data(h1_rd_data)
    );
    scratch_ram #(.DEPTH(N_HIDDEN)) a1 (
        .clk(clk), .wr(a1_wr), .rd_addr(mm2_src_addr), .rd_data(a1_rd_data)
    );
    scratch_ram #(.DEPTH(N_CLASSES)) s2 (
        .clk(clk), .wr(s2_wr), .rd_addr(am_src_addr), .rd_data(s2_rd_data)
    );

    matrix_multiply #(.IN_LEN(N_PIXELS), .OUT_LEN(N_HIDDEN)) mm1 (
        .clk(clk), .resetn(resetn), .start(run_mm1.start),
        .src_addr(mm1_src_addr), .src_data(pix_data),
        .wgt_addr(mm1_wgt_addr), .wgt_data(w1_data),
        .wr(h1_wr), .done(mm1_done)
    );

    relu #(.LEN(N_HIDDEN)) relu1 (
        .clk(clk), .resetn(resetn), .start(run_relu1.start),
        .src_addr(relu1_src_addr), .src_data(h1_rd_data),
        .wr(a1_wr), .done(relu1_done)
    );

    matrix_multiply #(.IN_LEN(N_HIDDEN), .OUT_LEN(N_CLASSES)) mm2 (
        .clk(clk), .resetn(resetn), .start(run_mm2.start),
        .src_addr(mm2_src_addr), .src_data(a1_rd_data),
        .wgt_addr(mm2_wgt_addr), .wgt_data(w2_data),
        .wr(s2_wr), .done(mm2_done)
    );

    argmax #(.LEN(N_CLASSES)) argmax1 (
        .clk(clk), .resetn(resetn), .start(run_am.start),
        .src_addr(am_src_addr), .src_data(s2_rd_data),
        .max_index(am_index), .done(am_done)
    );

endmodule

/* src/scratch_ram.sv */
`timescale 1ns/1ps

module scratch_ram #(
    parameter int DEPTH = 16
) (
    input  logic                 clk,
    input  nn_data_pkg::mem_wr_t wr,
    input  nn_data_pkg::addr_t   rd_addr,
    output nn_data_pkg::act_t    rd_data
);
    import nn_data_pkg::*;

    localparam int AW = $clog2(DEPTH);

    act_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr[AW-1:0]] <= wr.data;
        end
        // One cycle read latency
        rd_data <= mem[rd_addr[AW-1:0]];
    end

endmodule

/* src/weight_rom.sv */
`timescale 1ns/1ps

module weight_rom #(
    parameter int LAYER = 1
) (
    input  nn_data_pkg::addr_t addr,
    output nn_data_pkg::wgt_t  weight
);
    import nn_data_pkg::*;

    localparam int IN_LEN = (LAYER == 1) ? N_PIXELS : N_HIDDEN;

    int row;
    int col;
    int rem;

    // Address is row * IN_LEN + col
    always_comb begin
        col    = int'(addr) % IN_LEN;
        row    = int'(addr) / IN_LEN;
        rem    = (7 * col + 13 * row + 5 * LAYER) % 9;
        weight = wgt_t'(rem - 4);
    end

endmodule

/* tb/nn_props.sv */
`timescale 1ns/1ps

module nn_props (
    input logic                     clk,
    input logic                     resetn,
    input nn_ctrl_pkg::nn_state_t   state,
    input nn_ctrl_pkg::layer_run_t  run_mm1,
    input nn_ctrl_pkg::layer_run_t  run_relu1,
    input nn_ctrl_pkg::layer_run_t  run_mm2,
    input nn_ctrl_pkg::layer_run_t  run_am,
    input logic                     done
);
    import nn_ctrl_pkg::*;

    logic [3:0] starts;

    assign starts = {run_mm1.start, run_relu1.start, run_mm2.start, run_am.start};

    // No strobe stays high into a second cycle
    start_one_wide: assert property (@(posedge clk) disable iff (resetn)
        (starts != 4'b0) |=> ((starts & $past(starts)) == 4'b0))
        else $error("Layer start strobe wider than one cycle");

    start_single_unit: assert property (@(posedge clk) disable iff (resetn)
        $onehot0(starts))
        else $error("More than one layer unit started in one cycle");

    done_then_idle: assert property (@(posedge clk) disable iff (resetn)
        done |=> (state == IDLE))
        else $error("Sequencer not back in IDLE after done");

endmodule

/* tb/tb_neural_network.sv */
`timescale 1ns/1ps

module tb_neural_network;
    import nn_data_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_RANDOM   = 40;

    // One image end to end, summed from the unit latencies
    localparam int IMG_CYCLES = N_HIDDEN * (N_PIXELS + 2) + (N_HIDDEN + 2)
                              + N_CLASSES * (N_HIDDEN + 2) + (N_CLASSES + 2) + 5;
    localparam int IMG_BUDGET = IMG_CYCLES + 100;

    // Zero, ones, single pixel, busy test and the random set
    localparam int N_IMAGES = N_RANDOM + 4;

    logic                clk;
    logic                resetn;
    logic                start;
    logic [N_PIXELS-1:0] pixel_data;
    logic                done;
    logic [3:0]          class_index;

    integer seed = 2673;
    int     errors;
    int     checks;
    int     n_starts;
    int     n_dones;
    int     exp_q[$];
    string  name_q[$];

    neural_network dut0 (
        .clk(clk),
        .resetn(resetn),
        .start(start),
        .pixel_data(pixel_data),
        .done(done),
        .class_index(class_index)
    );

    bind neural_network nn_props props0 (
        .clk(clk),
        .resetn(resetn),
        .state(state),
        .run_mm1(run_mm1),
        .run_relu1(run_relu1),
        .run_mm2(run_mm2),
        .run_am(run_am),
        .done(done)
    );

    function automatic int weight_of(input int layer, input int j, input int i);
        return ((7 * i + 13 * j + 5 * layer) % 9) - 4;
    endfunction

    function automatic int nn_ref(input logic [N_PIXELS-1:0] img);
        int hid [N_HIDDEN];
        int score;
        int best;
        int best_idx;
        for (int j = 0; j < N_HIDDEN; j++) begin
            hid[j] = 0;
            for (int i = 0; i < N_PIXELS; i++) begin
                if (img[i]) begin
                    hid[j] += weight_of(1, j, i);
                end
            end
            if (hid[j] < 0) begin
                hid[j] = 0;
            end
        end
        best     = 0;
        best_idx = 0;
        for (int k = 0; k < N_CLASSES; k++) begin
            score = 0;
            for (int j = 0; j < N_HIDDEN; j++) begin
                score += hid[j] * weight_of(2, k, j);
            end
            // Strictly greater, so ties keep the lower index
            if ((k == 0) || (score > best)) begin
                best     = score;
                best_idx = k;
            end
        end
        return best_idx;
    endfunction

    task automatic drive_image(input logic [N_PIXELS-1:0] img, input string name,
                               input int exp);
        @(negedge clk);
        start      = 1'b1;
        pixel_data = img;
        exp_q.push_back(exp);
        name_q.push_back(name);
        n_starts++;
        @(negedge clk);
        start      = 1'b0;
        // Image should already be latched
        pixel_data = ~img;
    endtask

    task automatic wait_done(input string name);
        int cnt;
        cnt = 0;
        while ((done !== 1'b1) && (cnt < IMG_BUDGET)) begin
            @(negedge clk);
            cnt++;
        end
        if (done !== 1'b1) begin
            $display("Timed out waiting for done in test %s", name);
            errors++;
        end
    endtask

    task automatic run_image(input logic [N_PIXELS-1:0] img, input string name,
                             input int exp);
        drive_image(img, name, exp);
        wait_done(name);
    endtask

    task automatic check_hold(input string name, input int exp, input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            checks++;
            if (class_index !== 4'(exp)) begin
                $display("** Error [%s hold]: expected %0d, actual %0d",
                         name, exp, class_index);
                errors++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Compare each done pulse against the oldest outstanding image
    initial begin
        int    exp;
        string name;
        forever begin
            @(negedge clk);
            if ((resetn === 1'b0) && (done === 1'b1)) begin
                n_dones++;
                if (exp_q.size() == 0) begin
                    $display("Unexpected done pulse with no image in flight at %0t", $time);
                    errors++;
                end else begin
                    exp  = exp_q.pop_front();
                    name = name_q.pop_front();
                    checks++;
                    if (class_index !== 4'(exp)) begin
                        $display("** Error [%s]: expected %0d, actual %0d",
                                 name, exp, class_index);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        logic [N_PIXELS-1:0] img;
        int                  exp;
        errors     = 0;
        checks     = 0;
        n_starts   = 0;
        n_dones    = 0;
        resetn     = 1'b1;
        start      = 1'b0;
        pixel_data = '0;
        repeat (5) @(negedge clk);
        resetn = 1'b0;

        for (int c = 0; c < 10; c++) begin
            @(negedge clk);
            checks++;
            if (done !== 1'b0) begin
                $display("** Error [reset_done]: expected 0, actual %0b", done);
                errors++;
            end
            if (class_index !== 4'd0) begin
                $display("** Error [reset_class]: expected 0, actual %0d", class_index);
                errors++;
            end
        end

        // All hidden sums are zero, tie goes to class 0
        run_image('0, "zero_image", 0);
        check_hold("zero_image", 0, 5);

        img = '1;
        exp = nn_ref(img);
        run_image(img, "ones_image", exp);
        check_hold("ones_image", exp, 5);

        img     = '0;
        img[37] = 1'b1;
        exp     = nn_ref(img);
        run_image(img, "single_pixel", exp);
        check_hold("single_pixel", exp, 5);

        for (int n = 0; n < N_RANDOM; n++) begin
            img = {$random(seed), $random(seed)};
            run_image(img, $sformatf("random_%0d", n), nn_ref(img));
        end

        // Second start lands mid-run and must be dropped
        img = {$random(seed), $random(seed)};
        exp = nn_ref(img);
        drive_image(img, "busy_start", exp);
        repeat (100) @(negedge clk);
        start      = 1'b1;
        pixel_data = ~img;
        @(negedge clk);
        start = 1'b0;
        wait_done("busy_start");
        check_hold("busy_start", exp, IMG_CYCLES);

        repeat (5) @(negedge clk);
        if (n_dones != n_starts) begin
            $display("Done count %0d does not match accepted start count %0d",
                     n_dones, n_starts);
            errors++;
        end
        $display("Checks: %0d, errors: %0d, starts: %0d, dones: %0d",
                 checks, errors, n_starts, n_dones);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Two spare budgets cover reset, idle checks and the busy test's long hold
    initial begin
        repeat ((N_IMAGES + 2) * IMG_BUDGET) @(posedge clk);
        $display("Watchdog timed out after %0d cycles", (N_IMAGES + 2) * IMG_BUDGET);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
